// File: include/db_cfg.svh
/*
 * Register map and fixed levels of the daughterboard control block.
 * Each ATR bank takes base + 0..3 for its state words and base + 4 for direction.
 * SPI takes base + 0 divider, base + 1 control, base + 2 data.
 */
`ifndef DB_CFG_SVH
`define DB_CFG_SVH

// Settings bus addresses
`define DB_SR_MISC_OUTS 8'd8
`define DB_SR_SYNC      8'd9
`define DB_SR_LEDS      8'd16
`define DB_SR_FP_GPIO   8'd24
`define DB_SR_DB_GPIO   8'd32
`define DB_SR_SPI       8'd40

// Offsets inside a block
`define DB_ATR_DDR_OFS  8'd4
`define DB_SPI_DIV_OFS  8'd0
`define DB_SPI_CTRL_OFS 8'd1
`define DB_SPI_DATA_OFS 8'd2

// Widths
`define DB_GPIO_WIDTH   32
`define DB_SEN_WIDTH    8

// Idle levels of the SPI pins
`define DB_SPI_CLK_IDLE 1'b0
`define DB_SEN_IDLE     8'hFF

// Returned for any unmapped readback address
`define DB_BAD_READ     64'h0BADC0DE_0BADC0DE

`endif

// File: verilog/db_regs_pkg.sv
/*
 * Types of the settings bus and the readback path.
 * Readback addresses are 8 bits wide, matching the settings address.
 */
`default_nettype none

package db_regs_pkg;

  // Settings bus fields
  typedef logic [7:0]  sr_addr_t;
  typedef logic [31:0] sr_data_t;

  // Readback word
  typedef logic [63:0] rb_data_t;

  // Any other readback address returns the bad-read pattern
  typedef enum logic [7:0] {
    RB_MISC_IO = 8'd0,
    RB_SPI     = 8'd1,
    RB_LEDS    = 8'd2,
    RB_DB_GPIO = 8'd3,
    RB_FP_GPIO = 8'd4
  } rb_sel_e;

endpackage

`default_nettype wire

// File: verilog/fe_io_pkg.sv
/*
 * Front-end I/O types shared by the ATR banks and the SPI master.
 * spi_ctrl_t is packed with sen_mask in bits 13:6 and num_bits in bits 5:0.
 */
`default_nettype none

`include "db_cfg.svh"

package fe_io_pkg;

  typedef logic [`DB_GPIO_WIDTH-1:0] gpio_word_t;

  // Encoding is {run_tx, run_rx}, which is also the state register offset
  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    RX_ONLY     = 2'b01,
    TX_ONLY     = 2'b10,
    FULL_DUPLEX = 2'b11
  } atr_state_e;

  // A num_bits of 0 in the SPI control word means 32
  typedef struct packed {
    logic [`DB_SEN_WIDTH-1:0] sen_mask;
    logic [5:0]               num_bits;
  } spi_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/gpio_bank_if.sv
/*
 * Signals of one GPIO bank between its ATR block and the pin side.
 * The ATR block registers its outputs itself, so the bundle carries no clock.
 */
`default_nettype none

interface gpio_bank_if;
  import fe_io_pkg::*;

  gpio_word_t gpio_in;
  gpio_word_t gpio_out;
  gpio_word_t gpio_ddr;
  gpio_word_t gpio_sw_rb;

  modport atr  (input gpio_in, output gpio_out, output gpio_ddr, output gpio_sw_rb);
  modport pins (output gpio_in, input gpio_out, input gpio_ddr, input gpio_sw_rb);
endinterface

`default_nettype wire

// File: verilog/setting_reg.sv
/*
 * One settings register at a fixed address.
 * The payload takes the low bits of set_data; changed pulses for one cycle.
 */
`default_nettype none

module setting_reg #(
  parameter db_regs_pkg::sr_addr_t my_addr   = 8'd0,
  parameter type                   payload_t = logic [31:0],
  parameter payload_t              reset_val = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  set_stb,
  input  db_regs_pkg::sr_addr_t set_addr,
  input  db_regs_pkg::sr_data_t set_data,
  output payload_t              out,
  output logic                  changed
);

  logic hit;

  assign hit = set_stb && (set_addr == my_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      out     <= reset_val;
      changed <= 1'b0;
    end else begin
      changed <= hit;
      if (hit) begin
        out <= payload_t'(set_data[$bits(payload_t)-1:0]);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/gpio_atr.sv
/*
 * One ATR GPIO bank with four state words picked by {run_tx, run_rx} and a direction word.
 * gpio_out lags a run_rx/run_tx change by one cycle; gpio_sw_rb lags gpio_in by one.
 * Direction resets to all ones.
 */
`default_nettype none

`include "db_cfg.svh"

module gpio_atr #(
  parameter db_regs_pkg::sr_addr_t BASE = `DB_SR_LEDS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  set_stb,
  input  db_regs_pkg::sr_addr_t set_addr,
  input  db_regs_pkg::sr_data_t set_data,
  input  logic                  run_rx,
  input  logic                  run_tx,
  gpio_bank_if.atr              bank
);
  import db_regs_pkg::*;
  import fe_io_pkg::*;

  gpio_word_t atr_word [4];
  atr_state_e atr_state;

  // State words at BASE + 0..3 where the offset equals the ATR state encoding
  for (genvar i = 0; i < 4; i++) begin : g_state
    setting_reg #(
      .my_addr   (sr_addr_t'(BASE + i)),
      .payload_t (gpio_word_t),
      .reset_val ('0)
    ) sr_state (
      .clk      (clk),
      .rst      (rst),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data),
      .out      (atr_word[i]),
      .changed  ()
    );
  end

  // Direction word that starts with all pins as outputs
  setting_reg #(
    .my_addr   (sr_addr_t'(BASE + `DB_ATR_DDR_OFS)),
    .payload_t (gpio_word_t),
    .reset_val ({`DB_GPIO_WIDTH{1'b1}})
  ) sr_ddr (
    .clk      (clk),
    .rst      (rst),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .set_data (set_data),
    .out      (bank.gpio_ddr),
    .changed  ()
  );

  assign atr_state = atr_state_e'({run_tx, run_rx});

  always_ff @(posedge clk) begin
    if (rst) begin
      bank.gpio_out <= '0;
    end else begin
      bank.gpio_out <= atr_word[atr_state];
    end
  end

  // Input sampler for software readback
  always_ff @(posedge clk) begin
    bank.gpio_sw_rb <= bank.gpio_in;
  end

endmodule

`default_nettype wire

// File: verilog/simple_spi_core.sv
/*
 * SPI master programmed over the settings bus, MSB first, runs on clk.
 * Each sclk half period is divider+1 cycles; a data write while busy is dropped.
 * readback holds the last 8 bits shifted in from miso.
 */
`default_nettype none

`include "db_cfg.svh"

module simple_spi_core #(
  parameter db_regs_pkg::sr_addr_t BASE = `DB_SR_SPI
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     set_stb,
  input  db_regs_pkg::sr_addr_t    set_addr,
  input  db_regs_pkg::sr_data_t    set_data,
  output logic                     ready,
  output logic [7:0]               readback,
  output logic [`DB_SEN_WIDTH-1:0] sen,
  output logic                     sclk,
  output logic                     mosi,
  input  logic                     miso
);
  import db_regs_pkg::*;
  import fe_io_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_LOW, ST_HIGH} spi_state_e;

  logic [15:0] divider;
  spi_ctrl_t   ctrl;
  spi_state_e  state;
  logic [15:0] half_cnt;
  logic [5:0]  bits_left;
  logic [30:0] tx_shift;
  logic [7:0]  rx_shift;
  logic        start;
  logic        fall_next;

  setting_reg #(
    .my_addr   (sr_addr_t'(BASE + `DB_SPI_DIV_OFS)),
    .payload_t (logic [15:0]),
    .reset_val (16'd0)
  ) sr_divider (
    .clk      (clk),
    .rst      (rst),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .set_data (set_data),
    .out      (divider),
    .changed  ()
  );

  setting_reg #(
    .my_addr   (sr_addr_t'(BASE + `DB_SPI_CTRL_OFS)),
    .payload_t (spi_ctrl_t),
    .reset_val ('0)
  ) sr_ctrl (
    .clk      (clk),
    .rst      (rst),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .set_data (set_data),
    .out      (ctrl),
    .changed  ()
  );

  assign start     = ready && set_stb && (set_addr == sr_addr_t'(BASE + `DB_SPI_DATA_OFS));
  assign fall_next = (state == ST_HIGH) && (half_cnt == 16'd0) && (bits_left != 6'd1);
  assign readback  = rx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      ready     <= 1'b1;
      sen       <= `DB_SEN_IDLE;
      sclk      <= `DB_SPI_CLK_IDLE;
      mosi      <= 1'b0;
      half_cnt  <= '0;
      bits_left <= '0;
      rx_shift  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state     <= ST_LOW;
            ready     <= 1'b0;
            sen       <= `DB_SEN_IDLE & ~ctrl.sen_mask;
            half_cnt  <= divider;
            bits_left <= (ctrl.num_bits == 6'd0) ? 6'd32 : ctrl.num_bits;
            // First bit is on the line before the first rising edge
            mosi      <= set_data[31];
          end
        end
        ST_LOW: begin
          if (half_cnt != 16'd0) begin
            half_cnt <= half_cnt - 16'd1;
          end else begin
            sclk     <= ~`DB_SPI_CLK_IDLE;
            rx_shift <= {rx_shift[6:0], miso};
            half_cnt <= divider;
            state    <= ST_HIGH;
          end
        end
        ST_HIGH: begin
          if (half_cnt != 16'd0) begin
            half_cnt <= half_cnt - 16'd1;
          end else begin
            sclk     <= `DB_SPI_CLK_IDLE;
            half_cnt <= divider;
            if (bits_left == 6'd1) begin
              state <= ST_IDLE;
              ready <= 1'b1;
              sen   <= `DB_SEN_IDLE;
              mosi  <= 1'b0;
            end else begin
              bits_left <= bits_left - 6'd1;
              mosi      <= tx_shift[30];
              state     <= ST_LOW;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Remaining transmit bits advance on each falling edge except the last
  always_ff @(posedge clk) begin
    if (start) begin
      tx_shift <= set_data[30:0];
    end else if (fall_next) begin
      tx_shift <= {tx_shift[29:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: verilog/db_control.sv
/*
 * Daughterboard control with misc and sync registers, three ATR banks and an SPI master.
 * Readback is combinational; rb_stb at RB_SPI follows the SPI ready level.
 * The LED bank has no inputs and its direction output is not used.
 */
`default_nettype none

`include "db_cfg.svh"

module db_control (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     set_stb,
  input  db_regs_pkg::sr_addr_t    set_addr,
  input  db_regs_pkg::sr_data_t    set_data,
  input  db_regs_pkg::sr_addr_t    rb_addr,
  output logic                     rb_stb,
  output db_regs_pkg::rb_data_t    rb_data,
  input  logic                     run_rx,
  input  logic                     run_tx,
  input  fe_io_pkg::gpio_word_t    misc_ins,
  output fe_io_pkg::gpio_word_t    misc_outs,
  output logic                     sync,
  input  fe_io_pkg::gpio_word_t    fp_gpio_in,
  output fe_io_pkg::gpio_word_t    fp_gpio_out,
  output fe_io_pkg::gpio_word_t    fp_gpio_ddr,
  input  fe_io_pkg::gpio_word_t    db_gpio_in,
  output fe_io_pkg::gpio_word_t    db_gpio_out,
  output fe_io_pkg::gpio_word_t    db_gpio_ddr,
  output fe_io_pkg::gpio_word_t    leds,
  output logic [`DB_SEN_WIDTH-1:0] sen,
  output logic                     sclk,
  output logic                     mosi,
  input  logic                     miso
);
  import db_regs_pkg::*;
  import fe_io_pkg::*;

  logic       spi_ready;
  logic [7:0] spi_readback;

  setting_reg #(.my_addr(`DB_SR_MISC_OUTS), .payload_t(gpio_word_t), .reset_val('0)) sr_misc_outs (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .out(misc_outs), .changed());

  // Any write to the sync address fires the pulse whatever the data
  setting_reg #(.my_addr(`DB_SR_SYNC), .payload_t(logic), .reset_val(1'b0)) sr_sync (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .out(), .changed(sync));

  gpio_bank_if leds_if ();
  gpio_bank_if fp_if ();
  gpio_bank_if db_if ();

  assign leds_if.gpio_in = '0;
  assign fp_if.gpio_in   = fp_gpio_in;
  assign db_if.gpio_in   = db_gpio_in;

  assign leds        = leds_if.gpio_out;
  assign fp_gpio_out = fp_if.gpio_out;
  assign fp_gpio_ddr = fp_if.gpio_ddr;
  assign db_gpio_out = db_if.gpio_out;
  assign db_gpio_ddr = db_if.gpio_ddr;

  gpio_atr #(.BASE(`DB_SR_LEDS)) leds_atr (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx), .bank(leds_if.atr));

  gpio_atr #(.BASE(`DB_SR_FP_GPIO)) fp_atr (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx), .bank(fp_if.atr));

  gpio_atr #(.BASE(`DB_SR_DB_GPIO)) db_atr (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .run_rx(run_rx), .run_tx(run_tx), .bank(db_if.atr));

  simple_spi_core #(.BASE(`DB_SR_SPI)) spi_core (
    .clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .ready(spi_ready), .readback(spi_readback),
    .sen(sen), .sclk(sclk), .mosi(mosi), .miso(miso));

  // Readback mux
  always_comb begin
    rb_stb = 1'b1;
    case (rb_addr)
      RB_MISC_IO: rb_data = {misc_ins, misc_outs};
      RB_SPI: begin
        // Ready level lets a late read after a transfer still see a strobe
        rb_stb  = spi_ready;
        rb_data = rb_data_t'(spi_readback);
      end
      RB_LEDS:    rb_data = rb_data_t'(leds);
      RB_DB_GPIO: rb_data = rb_data_t'(db_if.gpio_sw_rb);
      RB_FP_GPIO: rb_data = rb_data_t'(fp_if.gpio_sw_rb);
      default:    rb_data = `DB_BAD_READ;
    endcase
  end

endmodule

`default_nettype wire

// File: verif/db_control_tb.sv
/*
 * Testbench for db_control. Inputs change on the falling clock edge and
 * outputs are checked there, away from the rising edge. miso loops back from mosi.
 */
`default_nettype none

`include "db_cfg.svh"

module db_control_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import db_regs_pkg::*;
  import fe_io_pkg::*;

  localparam int NUM_XFERS = 6;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     set_stb;
  sr_addr_t                 set_addr;
  sr_data_t                 set_data;
  sr_addr_t                 rb_addr;
  logic                     rb_stb;
  rb_data_t                 rb_data;
  logic                     run_rx;
  logic                     run_tx;
  gpio_word_t               misc_ins;
  gpio_word_t               misc_outs;
  logic                     sync;
  gpio_word_t               fp_gpio_in;
  gpio_word_t               fp_gpio_out;
  gpio_word_t               fp_gpio_ddr;
  gpio_word_t               db_gpio_in;
  gpio_word_t               db_gpio_out;
  gpio_word_t               db_gpio_ddr;
  gpio_word_t               leds;
  logic [`DB_SEN_WIDTH-1:0] sen;
  logic                     sclk;
  logic                     mosi;
  logic                     miso;

  int         seed = 30;
  int         cycle_budget = 2000;
  int         sclk_rises = 0;
  logic       sync_due = 1'b0;
  gpio_word_t atr_model [3][4];
  sr_addr_t   bank_base [3] = '{`DB_SR_LEDS, `DB_SR_FP_GPIO, `DB_SR_DB_GPIO};

  db_control uut (.*);

  assign miso = mosi;

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s (at %0d ns)", msg, $time);
    abort_run();
  endtask

  task automatic write_setting(input sr_addr_t addr, input sr_data_t data);
    @(negedge clk);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge clk);
    set_stb  = 1'b0;
  endtask

  task automatic drive_pins(input gpio_word_t misc, fp, db);
    @(negedge clk);
    misc_ins   = misc;
    fp_gpio_in = fp;
    db_gpio_in = db;
  endtask

  // Change the ATR state, then hold it long enough for the registered outputs
  task automatic set_run(input logic tx, input logic rx);
    @(negedge clk);
    run_tx = tx;
    run_rx = rx;
    repeat (2) @(negedge clk);
  endtask

  task automatic check_readback(input sr_addr_t addr, input logic exp_stb,
                                input rb_data_t exp_data, input string what);
    @(negedge clk);
    rb_addr = addr;
    #1;
    assert (rb_stb === exp_stb && rb_data === exp_data)
      else report_mismatch($sformatf("%s: rb_stb %b rb_data %h, expected %b %h",
                                     what, rb_stb, rb_data, exp_stb, exp_data));
  endtask

  // Sync is expected high for the cycle after a sampled write to its address
  always @(posedge clk) begin
    sync_due <= !rst && set_stb && (set_addr == `DB_SR_SYNC);
  end

  always @(negedge clk) begin
    assert (sync === sync_due)
      else report_mismatch($sformatf("sync is %b, expected %b", sync, sync_due));
  end

  always @(posedge sclk) begin
    sclk_rises++;
  end

  // Budget grows with each SPI transfer that the stimulus sets up
  initial begin : watchdog
    int elapsed;
    elapsed = 0;
    while (elapsed < cycle_budget) begin
      @(posedge clk);
      elapsed++;
    end
    report_failure($sformatf("Watchdog expired after %0d cycles", elapsed));
  end

  initial begin : main
    gpio_word_t  w;
    gpio_word_t  fp_in;
    gpio_word_t  db_in;
    atr_state_e  st;
    spi_ctrl_t   ctrl;
    sr_data_t    spi_data;
    logic [7:0]  mask;
    logic [7:0]  exp_rb;
    int          nb;
    int          div;
    int          limit;
    int          waited;

    rst        = 1'b1;
    set_stb    = 1'b0;
    set_addr   = '0;
    set_data   = '0;
    rb_addr    = '0;
    run_rx     = 1'b0;
    run_tx     = 1'b0;
    misc_ins   = '0;
    fp_gpio_in = '0;
    db_gpio_in = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Reset values
    assert (misc_outs === '0 && sync === 1'b0 && leds === '0)
      else report_mismatch("misc_outs, sync or leds not cleared by reset");
    assert (fp_gpio_out === '0 && db_gpio_out === '0)
      else report_mismatch("GPIO outputs not cleared by reset");
    assert (fp_gpio_ddr === '1 && db_gpio_ddr === '1)
      else report_mismatch("GPIO direction not all ones after reset");
    assert (sclk === `DB_SPI_CLK_IDLE && sen === `DB_SEN_IDLE && mosi === 1'b0)
      else report_mismatch($sformatf("SPI pins after reset sclk %b sen %h mosi %b",
                                     sclk, sen, mosi));
    check_readback(RB_SPI, 1'b1, '0, "SPI readback after reset");

    // Misc word, sync pulse and unmapped reads
    w = $random(seed);
    drive_pins($random(seed), '0, '0);
    write_setting(`DB_SR_MISC_OUTS, w);
    assert (misc_outs === w)
      else report_mismatch($sformatf("misc_outs %h expected %h", misc_outs, w));
    check_readback(RB_MISC_IO, 1'b1, {misc_ins, w}, "RB_MISC_IO");
    write_setting(`DB_SR_SYNC, $random(seed));
    check_readback(8'd5, 1'b1, `DB_BAD_READ, "unmapped address 5");
    check_readback(8'hFF, 1'b1, `DB_BAD_READ, "unmapped address 255");

    // ATR words for every bank and state
    for (int b = 0; b < 3; b++) begin
      for (int s = 0; s < 4; s++) begin
        atr_model[b][s] = $random(seed);
        write_setting(sr_addr_t'(bank_base[b] + s), atr_model[b][s]);
      end
    end
    for (int i = 0; i < 4; i++) begin
      set_run(i[1], i[0]);
      st = atr_state_e'({run_tx, run_rx});
      assert (leds === atr_model[0][st])
        else report_mismatch($sformatf("leds %h in %s", leds, st.name()));
      assert (fp_gpio_out === atr_model[1][st])
        else report_mismatch($sformatf("fp_gpio_out %h in %s", fp_gpio_out, st.name()));
      assert (db_gpio_out === atr_model[2][st])
        else report_mismatch($sformatf("db_gpio_out %h in %s", db_gpio_out, st.name()));
      check_readback(RB_LEDS, 1'b1, rb_data_t'(atr_model[0][st]), "RB_LEDS");
    end

    // Direction registers and input sampling
    w = $random(seed);
    write_setting(`DB_SR_FP_GPIO + `DB_ATR_DDR_OFS, w);
    assert (fp_gpio_ddr === w)
      else report_mismatch($sformatf("fp_gpio_ddr %h expected %h", fp_gpio_ddr, w));
    w = $random(seed);
    write_setting(`DB_SR_DB_GPIO + `DB_ATR_DDR_OFS, w);
    assert (db_gpio_ddr === w)
      else report_mismatch($sformatf("db_gpio_ddr %h expected %h", db_gpio_ddr, w));
    fp_in = $random(seed);
    db_in = $random(seed);
    drive_pins(misc_ins, fp_in, db_in);
    repeat (2) @(negedge clk);
    check_readback(RB_FP_GPIO, 1'b1, rb_data_t'(fp_in), "RB_FP_GPIO");
    check_readback(RB_DB_GPIO, 1'b1, rb_data_t'(db_in), "RB_DB_GPIO");

    // SPI transfers with mosi looped back to miso
    for (int t = 0; t < NUM_XFERS; t++) begin
      div           = {$random(seed)} % 4;
      nb            = 8 + ({$random(seed)} % 25);
      mask          = $random(seed);
      spi_data      = $random(seed);
      ctrl.sen_mask = mask;
      ctrl.num_bits = 6'(nb);
      limit         = 2 * nb * (div + 1) + 20;
      cycle_budget += limit;
      exp_rb        = 8'(spi_data >> (32 - nb));
      write_setting(`DB_SR_SPI + `DB_SPI_DIV_OFS, sr_data_t'(div));
      write_setting(`DB_SR_SPI + `DB_SPI_CTRL_OFS, sr_data_t'(ctrl));
      sclk_rises = 0;
      write_setting(`DB_SR_SPI + `DB_SPI_DATA_OFS, spi_data);
      rb_addr = RB_SPI;
      #1;
      assert (rb_stb === 1'b0)
        else report_mismatch("SPI ready still high after a data write");
      waited = 0;
      while (rb_stb !== 1'b1) begin
        assert (sen === (`DB_SEN_IDLE & ~mask))
          else report_mismatch($sformatf("sen %h during transfer, mask %h", sen, mask));
        if (waited > limit) begin
          report_failure("SPI ready did not return within the expected time");
        end
        @(negedge clk);
        #1;
        waited++;
      end
      assert (sen === `DB_SEN_IDLE && sclk === `DB_SPI_CLK_IDLE)
        else report_mismatch($sformatf("after transfer sen %h sclk %b", sen, sclk));
      assert (sclk_rises == nb)
        else report_mismatch($sformatf("%0d sclk rising edges, expected %0d", sclk_rises, nb));
      assert (rb_data === rb_data_t'(exp_rb))
        else report_mismatch($sformatf("SPI readback %h expected %h", rb_data, exp_rb));
    end

    @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/db_regs_pkg.sv
verilog/fe_io_pkg.sv
verilog/gpio_bank_if.sv
verilog/setting_reg.sv
verilog/gpio_atr.sv
verilog/simple_spi_core.sv
verilog/db_control.sv
verif/db_control_tb.sv
